//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
hw/mem_pkg.sv
hw/dcache_if.sv
hw/dcache.sv
hw/operand_swap.sv
hw/mem_stage.sv
verification/mem_stage_sva.sv
verification/mem_stage_tb.sv

//--- hw/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                          clk,
    input  logic                          rst,
    dcache_if.cache                       port,
    input  logic                          fill_valid,
    input  logic [mem_pkg::line_w-1:0]    fill_data,
    input  logic                          wb_valid,
    input  logic [mem_pkg::addr_w-1:0]    wb_addr,
    input  logic [mem_pkg::data_w-1:0]    wb_data,
    input  logic [mem_pkg::size_bits-1:0] wb_size,
    output logic                          fill_req,
    output logic [mem_pkg::addr_w-1:0]    fill_addr,
    output logic                          mem_wr,
    output logic [mem_pkg::addr_w-1:0]    mem_wr_addr,
    output logic [mem_pkg::data_w-1:0]    mem_wr_data,
    output logic [mem_pkg::size_bits-1:0] mem_wr_size
);
    import mem_pkg::*;

    logic [tag_w-1:0]     tag_mem  [num_lines];
    logic [line_w-1:0]    data_mem [num_lines];
    logic [num_lines-1:0] line_valid;

    logic [idx_w-1:0]      rd_idx;
    logic [off_w-1:0]      rd_off;
    logic [tag_w-1:0]      rd_tag;
    logic                  rd_hit;
    logic                  rd_miss;

    logic [idx_w-1:0]      wb_idx;
    logic [off_w-1:0]      wb_off;
    logic [tag_w-1:0]      wb_tag;
    logic                  wb_hit;
    logic [line_bytes-1:0] wb_be;
    logic [line_w-1:0]     wb_bits;
    logic [line_w-1:0]     wb_shift;
    logic [line_w-1:0]     wb_line;

    logic                  fill_pend;   // second state of the fill sequencer.
    logic                  fill_start;
    logic                  fill_done;
    logic [idx_w-1:0]      fill_idx;

    function automatic logic [line_bytes-1:0] size_mask(input logic [size_bits-1:0] sz);
        case (sz)
            size_b: size_mask = line_bytes'(8'h01);
            size_w: size_mask = line_bytes'(8'h03);
            size_d: size_mask = line_bytes'(8'h0f);
            size_q: size_mask = line_bytes'(8'hff);
        endcase
    endfunction

    // low bytes of the shifted line, cut to the access size.
    function automatic logic [data_w-1:0] item(input logic [line_w-1:0] bits,
                                               input logic [size_bits-1:0] sz);
        case (sz)
            size_b: item = data_w'(bits[7:0]);
            size_w: item = data_w'(bits[15:0]);
            size_d: item = data_w'(bits[31:0]);
            size_q: item = bits[data_w-1:0];
        endcase
    endfunction

    // load lookup
    assign rd_idx  = port.addr[off_w +: idx_w];
    assign rd_off  = port.addr[off_w-1:0];
    assign rd_tag  = port.addr[addr_w-1 -: tag_w];
    assign rd_hit  = line_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign rd_miss = port.req && !rd_hit;

    assign port.hit   = rd_hit;
    assign port.rdata = item(data_mem[rd_idx] >> {rd_off, 3'b000}, port.size);
    assign port.busy  = fill_pend;

    // writeback merge into the hit line
    assign wb_idx = wb_addr[off_w +: idx_w];
    assign wb_off = wb_addr[off_w-1:0];
    assign wb_tag = wb_addr[addr_w-1 -: tag_w];
    assign wb_hit = line_valid[wb_idx] && (tag_mem[wb_idx] == wb_tag);

    always_comb begin
        wb_be    = size_mask(wb_size) << wb_off;
        wb_shift = {{(line_w - data_w){1'b0}}, wb_data} << {wb_off, 3'b000};
        for (int b = 0; b < line_bytes; b++) begin
            wb_bits[b*8 +: 8] = {8{wb_be[b]}};
        end
        wb_line = (data_mem[wb_idx] & ~wb_bits) | (wb_shift & wb_bits);
    end

    assign fill_start = rd_miss && !fill_pend;
    assign fill_done  = fill_pend && fill_valid;
    assign fill_idx   = fill_addr[off_w +: idx_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_pend <= 1'b0;
            fill_req  <= 1'b0;
        end else begin
            fill_req <= fill_start;         // one strobe per miss.
            if (fill_start) begin
                fill_pend <= 1'b1;
            end else if (fill_done) begin
                fill_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start) begin
            fill_addr <= {port.addr[addr_w-1:off_w], {off_w{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
        end else if (fill_done) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_mem[fill_idx] <= fill_data;
            tag_mem[fill_idx]  <= fill_addr[addr_w-1 -: tag_w];
        end else if (wb_valid && wb_hit) begin
            data_mem[wb_idx] <= wb_line;
        end
    end

    // write through, every writeback goes out a cycle later.
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr <= 1'b0;
        end else begin
            mem_wr <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            mem_wr_addr <= wb_addr;
            mem_wr_data <= wb_data;
            mem_wr_size <= wb_size;
        end
    end

endmodule

//--- hw/dcache_if.sv
`timescale 1ns/1ps

interface dcache_if;
    import mem_pkg::*;

    logic                 req;    // held instruction has a load.
    logic [addr_w-1:0]    addr;
    logic [size_bits-1:0] size;
    logic                 hit;
    logic [data_w-1:0]    rdata;  // aligned item, zero extended.
    logic                 busy;   // line fill outstanding.

    // stage side
    modport drive (
        output req,
        output addr,
        output size,
        input  hit,
        input  rdata,
        input  busy
    );

    // cache side
    modport cache (
        input  req,
        input  addr,
        input  size,
        output hit,
        output rdata,
        output busy
    );

endinterface

//--- hw/mem_pkg.sv
package mem_pkg;

    localparam int addr_w     = 32;
    localparam int data_w     = 64;
    localparam int line_w     = 128;
    localparam int line_bytes = line_w / 8;
    localparam int num_lines  = 16;
    localparam int off_w      = $clog2(line_bytes);
    localparam int idx_w      = $clog2(num_lines);
    localparam int tag_w      = addr_w - idx_w - off_w;

    localparam int seg_w      = 16;
    localparam int num_srcs   = 4;                 // register and segment inputs each.
    localparam int src_idx_w  = $clog2(num_srcs);
    localparam int num_ops    = 4;
    localparam int num_dests  = 2;
    localparam int num_sizes  = 4;                 // one override bit per size.

    localparam int size_bits  = 2;
    localparam int src_bits   = 4;
    localparam int kind_bits  = 2;

    // access size, 1 << code bytes.
    localparam logic [size_bits-1:0] size_b = 2'd0;
    localparam logic [size_bits-1:0] size_w = 2'd1;
    localparam logic [size_bits-1:0] size_d = 2'd2;
    localparam logic [size_bits-1:0] size_q = 2'd3;

    localparam logic [src_bits-1:0] src_reg0 = 4'd0;
    localparam logic [src_bits-1:0] src_reg1 = 4'd1;
    localparam logic [src_bits-1:0] src_reg2 = 4'd2;
    localparam logic [src_bits-1:0] src_reg3 = 4'd3;
    localparam logic [src_bits-1:0] src_seg0 = 4'd4;
    localparam logic [src_bits-1:0] src_seg1 = 4'd5;
    localparam logic [src_bits-1:0] src_seg2 = 4'd6;
    localparam logic [src_bits-1:0] src_seg3 = 4'd7;
    localparam logic [src_bits-1:0] src_mem  = 4'd8;   // loaded item.
    localparam logic [src_bits-1:0] src_imm  = 4'd9;
    localparam logic [src_bits-1:0] src_eip  = 4'd10;
    localparam logic [src_bits-1:0] src_none = 4'd11;

    localparam logic [kind_bits-1:0] dest_none = 2'd0;
    localparam logic [kind_bits-1:0] dest_reg  = 2'd1;
    localparam logic [kind_bits-1:0] dest_seg  = 2'd2;
    localparam logic [kind_bits-1:0] dest_mem  = 2'd3;

endpackage

//--- hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   valid_in,
    input  logic                                                   fwd_stall,
    input  logic [mem_pkg::size_bits-1:0]                          opsize_in,
    input  logic [mem_pkg::num_sizes-1:0]                          memsize_ovr,
    input  logic                                                   mem_rd,
    input  logic [mem_pkg::addr_w-1:0]                             mem_addr,
    input  logic [mem_pkg::num_srcs-1:0][mem_pkg::data_w-1:0]      reg_data,
    input  logic [mem_pkg::num_srcs-1:0][mem_pkg::seg_w-1:0]       seg_data,
    input  logic [mem_pkg::data_w-1:0]                             imm,
    input  logic [mem_pkg::addr_w-1:0]                             eip_in,
    input  logic [mem_pkg::num_ops-1:0][mem_pkg::src_bits-1:0]     op_sel,
    input  logic [mem_pkg::num_dests-1:0][mem_pkg::src_bits-1:0]   dest_sel,
    input  logic                                                   wb_valid,
    input  logic [mem_pkg::addr_w-1:0]                             wb_addr,
    input  logic [mem_pkg::data_w-1:0]                             wb_data,
    input  logic [mem_pkg::size_bits-1:0]                          wb_size,
    input  logic                                                   fill_valid,
    input  logic [mem_pkg::line_w-1:0]                             fill_data,
    output logic                                                   stall,
    output logic                                                   valid_out,
    output logic [mem_pkg::size_bits-1:0]                          size_out,
    output logic [mem_pkg::num_ops-1:0][mem_pkg::data_w-1:0]       op_val,
    output logic [mem_pkg::num_dests-1:0][mem_pkg::addr_w-1:0]     dest_addr,
    output logic [mem_pkg::num_dests-1:0][mem_pkg::kind_bits-1:0]  dest_kind,
    output logic [mem_pkg::addr_w-1:0]                             eip_out,
    output logic                                                   fill_req,
    output logic [mem_pkg::addr_w-1:0]                             fill_addr,
    output logic                                                   mem_wr,
    output logic [mem_pkg::addr_w-1:0]                             mem_wr_addr,
    output logic [mem_pkg::data_w-1:0]                             mem_wr_data,
    output logic [mem_pkg::size_bits-1:0]                          mem_wr_size
);
    import mem_pkg::*;

    logic [size_bits-1:0]                 acc_size;
    logic                                 cache_stall;
    logic                                 advance;
    logic [num_ops-1:0][data_w-1:0]       op_val_c;
    logic [num_dests-1:0][addr_w-1:0]     dest_addr_c;
    logic [num_dests-1:0][kind_bits-1:0]  dest_kind_c;

    dcache_if dc_bus ();

    // a single override bit names the size, anything else keeps opsize.
    always_comb begin
        case (memsize_ovr)
            4'b0001: acc_size = size_b;
            4'b0010: acc_size = size_w;
            4'b0100: acc_size = size_d;
            4'b1000: acc_size = size_q;
            default: acc_size = opsize_in;
        endcase
    end

    assign dc_bus.req  = valid_in && mem_rd;
    assign dc_bus.addr = mem_addr;
    assign dc_bus.size = acc_size;

    assign cache_stall = dc_bus.req && (!dc_bus.hit || dc_bus.busy);
    assign stall       = cache_stall || fwd_stall;   // holds the instruction upstream.
    assign advance     = valid_in && !stall;

    dcache u_dcache (
        .clk         (clk),
        .rst         (rst),
        .port        (dc_bus.cache),
        .fill_valid  (fill_valid),
        .fill_data   (fill_data),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .wb_size     (wb_size),
        .fill_req    (fill_req),
        .fill_addr   (fill_addr),
        .mem_wr      (mem_wr),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_wr_size (mem_wr_size)
    );

    operand_swap u_operand_swap (
        .reg_data  (reg_data),
        .seg_data  (seg_data),
        .mem_data  (dc_bus.rdata),
        .imm       (imm),
        .eip       (eip_in),
        .op_sel    (op_sel),
        .dest_sel  (dest_sel),
        .mem_addr  (mem_addr),
        .op_val    (op_val_c),
        .dest_addr (dest_addr_c),
        .dest_kind (dest_kind_c)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= advance;
        end
    end

    // towards execute, held while nothing moves.
    always_ff @(posedge clk) begin
        if (advance) begin
            size_out  <= acc_size;
            eip_out   <= eip_in;
            op_val    <= op_val_c;
            dest_addr <= dest_addr_c;
            dest_kind <= dest_kind_c;
        end
    end

endmodule

//--- hw/operand_swap.sv
`timescale 1ns/1ps

module operand_swap (
    input  logic [mem_pkg::num_srcs-1:0][mem_pkg::data_w-1:0]      reg_data,
    input  logic [mem_pkg::num_srcs-1:0][mem_pkg::seg_w-1:0]       seg_data,
    input  logic [mem_pkg::data_w-1:0]                             mem_data,
    input  logic [mem_pkg::data_w-1:0]                             imm,
    input  logic [mem_pkg::addr_w-1:0]                             eip,
    input  logic [mem_pkg::num_ops-1:0][mem_pkg::src_bits-1:0]     op_sel,
    input  logic [mem_pkg::num_dests-1:0][mem_pkg::src_bits-1:0]   dest_sel,
    input  logic [mem_pkg::addr_w-1:0]                             mem_addr,
    output logic [mem_pkg::num_ops-1:0][mem_pkg::data_w-1:0]       op_val,
    output logic [mem_pkg::num_dests-1:0][mem_pkg::addr_w-1:0]     dest_addr,
    output logic [mem_pkg::num_dests-1:0][mem_pkg::kind_bits-1:0]  dest_kind
);
    import mem_pkg::*;

    // position of a code inside its group of four.
    function automatic logic [src_idx_w-1:0] slot(input logic [src_bits-1:0] sel,
                                                  input logic [src_bits-1:0] base);
        slot = src_idx_w'(sel - base);
    endfunction

    always_comb begin
        for (int i = 0; i < num_ops; i++) begin
            case (op_sel[i])
                src_reg0, src_reg1, src_reg2, src_reg3: begin
                    op_val[i] = reg_data[slot(op_sel[i], src_reg0)];
                end
                src_seg0, src_seg1, src_seg2, src_seg3: begin
                    op_val[i] = data_w'(seg_data[slot(op_sel[i], src_seg0)]);
                end
                src_mem: begin
                    op_val[i] = mem_data;
                end
                src_imm: begin
                    op_val[i] = imm;
                end
                src_eip: begin
                    op_val[i] = data_w'(eip);
                end
                src_none: begin
                    op_val[i] = '0;
                end
                default: begin
                    op_val[i] = '0;           // unused codes read as zero.
                end
            endcase
        end
    end

    // register and segment destinations carry their index as the address.
    always_comb begin
        for (int j = 0; j < num_dests; j++) begin
            case (dest_sel[j])
                src_reg0, src_reg1, src_reg2, src_reg3: begin
                    dest_kind[j] = dest_reg;
                    dest_addr[j] = addr_w'(slot(dest_sel[j], src_reg0));
                end
                src_seg0, src_seg1, src_seg2, src_seg3: begin
                    dest_kind[j] = dest_seg;
                    dest_addr[j] = addr_w'(slot(dest_sel[j], src_seg0));
                end
                src_mem: begin
                    dest_kind[j] = dest_mem;
                    dest_addr[j] = mem_addr;
                end
                default: begin
                    dest_kind[j] = dest_none;  // also imm, eip and src_none.
                    dest_addr[j] = '0;
                end
            endcase
        end
    end

endmodule

//--- verification/mem_stage_sva.sv
`timescale 1ns/1ps

module mem_stage_sva (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic fwd_stall,
    input logic valid_out,
    input logic fill_req,
    input logic fill_valid,
    input logic mem_wr
);
    logic fill_open;   // a fill request has not been answered yet.

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_open <= 1'b0;
        end else if (fill_req) begin
            fill_open <= 1'b1;
        end else if (fill_valid) begin
            fill_open <= 1'b0;
        end
    end

    a_one_fill: assert property (@(posedge clk) disable iff (rst) fill_req |-> !fill_open)
        else $error("second fill request before the first was answered");

    a_fwd_stall: assert property (@(posedge clk) disable iff (rst) fwd_stall |-> stall)
        else $error("fwd_stall high without stall");

    a_stall_bubble: assert property (@(posedge clk) disable iff (rst) stall |=> !valid_out)
        else $error("valid_out high in the cycle after a stall");

    a_reset_quiet: assert property (@(posedge clk) rst |=> !valid_out && !fill_req && !mem_wr)
        else $error("control output high after reset");

endmodule

bind mem_stage mem_stage_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .fwd_stall  (fwd_stall),
    .valid_out  (valid_out),
    .fill_req   (fill_req),
    .fill_valid (fill_valid),
    .mem_wr     (mem_wr)
);

//--- verification/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;
    import mem_pkg::*;

    localparam int n_instr    = 2000;
    localparam int max_cycles = 40 * n_instr + 100;
    localparam int win_bytes  = 512;                 // 32 lines over 16 sets.
    localparam logic [addr_w-1:0] win_base = 32'h0001_2000;

    logic clk;
    logic rst;
    logic valid_in;
    logic fwd_stall;
    logic [size_bits-1:0] opsize_in;
    logic [num_sizes-1:0] memsize_ovr;
    logic mem_rd;
    logic [addr_w-1:0] mem_addr;
    logic [num_srcs-1:0][data_w-1:0] reg_data;
    logic [num_srcs-1:0][seg_w-1:0] seg_data;
    logic [data_w-1:0] imm;
    logic [addr_w-1:0] eip_in;
    logic [num_ops-1:0][src_bits-1:0] op_sel;
    logic [num_dests-1:0][src_bits-1:0] dest_sel;
    logic wb_valid;
    logic [addr_w-1:0] wb_addr;
    logic [data_w-1:0] wb_data;
    logic [size_bits-1:0] wb_size;
    logic fill_valid;
    logic [line_w-1:0] fill_data;
    logic stall;
    logic valid_out;
    logic [size_bits-1:0] size_out;
    logic [num_ops-1:0][data_w-1:0] op_val;
    logic [num_dests-1:0][addr_w-1:0] dest_addr;
    logic [num_dests-1:0][kind_bits-1:0] dest_kind;
    logic [addr_w-1:0] eip_out;
    logic fill_req;
    logic [addr_w-1:0] fill_addr;
    logic mem_wr;
    logic [addr_w-1:0] mem_wr_addr;
    logic [data_w-1:0] mem_wr_data;
    logic [size_bits-1:0] mem_wr_size;

    logic [7:0] ref_mem [win_bytes];    // what loads must return, written when wb is driven.
    logic [7:0] ext_mem [win_bytes];    // external memory, follows mem_wr.
    logic [tag_w-1:0] model_tag [num_lines];
    logic [num_lines-1:0] model_valid;

    logic [num_ops-1:0][data_w-1:0] exp_op_q [$];
    logic [num_dests-1:0][addr_w-1:0] exp_daddr_q [$];
    logic [num_dests-1:0][kind_bits-1:0] exp_dkind_q [$];
    logic [size_bits-1:0] exp_size_q [$];
    logic [addr_w-1:0] exp_eip_q [$];
    logic [addr_w-1:0] wr_addr_q [$];
    logic [data_w-1:0] wr_data_q [$];
    logic [size_bits-1:0] wr_size_q [$];

    int unsigned rnd;
    int cycle;
    int value_errors;
    int proto_errors;
    int driven;
    int accepted;
    int fills_seen;
    int fill_wait;
    logic fill_open;
    logic cur_miss;
    logic line_in;      // the held load's line has been installed.
    logic prev_stall;
    logic prev_wb;
    logic [addr_w-1:0] fill_line;

    mem_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle++;
            if (cycle >= max_cycles) begin
                $display("timeout: run did not finish within %0d cycles", max_cycles);
                $display("TESTS FAILED");
                $finish;
            end
        end
    end

    // multiplicative hash, every address bit reaches the byte.
    function automatic logic [7:0] init_byte(input logic [addr_w-1:0] a);
        logic [addr_w-1:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic int widx(input logic [addr_w-1:0] a);
        return int'((a - win_base) % win_bytes);
    endfunction

    function automatic logic [size_bits-1:0] access_size(input logic [num_sizes-1:0] ovr,
                                                        input logic [size_bits-1:0] osz);
        logic [size_bits-1:0] sz;
        sz = osz;
        if ($countones(ovr) == 1) begin
            for (int i = 0; i < num_sizes; i++) begin
                if (ovr[i]) sz = size_bits'(i);
            end
        end
        return sz;
    endfunction

    function automatic logic [data_w-1:0] load_item(input logic [addr_w-1:0] a,
                                                    input logic [size_bits-1:0] sz);
        logic [data_w-1:0] v;
        v = '0;
        for (int k = 0; k < (1 << sz); k++) begin
            v[k*8 +: 8] = ref_mem[widx(a + k)];
        end
        return v;
    endfunction

    function automatic logic [data_w-1:0] pick_src(input logic [src_bits-1:0] code,
                                                   input logic [data_w-1:0] item);
        if (code <= src_reg3) return reg_data[code[1:0]];
        if (code <= src_seg3) return data_w'(seg_data[code[1:0]]);
        if (code == src_mem) return item;
        if (code == src_imm) return imm;
        if (code == src_eip) return data_w'(eip_in);
        return '0;
    endfunction

    task automatic check_val(input string name, input logic [data_w-1:0] exp_v,
                             input logic [data_w-1:0] got);
        if (got !== exp_v) begin
            $display("error: %s expected %h got %h", name, exp_v, got);
            value_errors++;
        end
    endtask

    task automatic push_expected();
        logic [size_bits-1:0] sz;
        logic [data_w-1:0] item;
        logic [num_ops-1:0][data_w-1:0] ops;
        logic [num_dests-1:0][addr_w-1:0] daddr;
        logic [num_dests-1:0][kind_bits-1:0] dkind;
        sz = access_size(memsize_ovr, opsize_in);
        item = load_item(mem_addr, sz);
        for (int i = 0; i < num_ops; i++) begin
            ops[i] = pick_src(op_sel[i], item);
        end
        for (int j = 0; j < num_dests; j++) begin
            daddr[j] = '0;
            dkind[j] = dest_none;
            if (dest_sel[j] <= src_reg3) begin
                dkind[j] = dest_reg;
                daddr[j] = addr_w'(dest_sel[j][1:0]);
            end else if (dest_sel[j] <= src_seg3) begin
                dkind[j] = dest_seg;
                daddr[j] = addr_w'(dest_sel[j][1:0]);
            end else if (dest_sel[j] == src_mem) begin
                dkind[j] = dest_mem;
                daddr[j] = mem_addr;
            end
        end
        exp_op_q.push_back(ops);
        exp_daddr_q.push_back(daddr);
        exp_dkind_q.push_back(dkind);
        exp_size_q.push_back(sz);
        exp_eip_q.push_back(eip_in);
    endtask

    task automatic check_output();
        logic [num_ops-1:0][data_w-1:0] ops;
        logic [num_dests-1:0][addr_w-1:0] daddr;
        logic [num_dests-1:0][kind_bits-1:0] dkind;
        if (exp_size_q.size() == 0) begin
            $display("valid_out came with no accepted instruction waiting");
            proto_errors++;
        end else begin
            ops = exp_op_q.pop_front();
            daddr = exp_daddr_q.pop_front();
            dkind = exp_dkind_q.pop_front();
            check_val("size_out", data_w'(exp_size_q.pop_front()), data_w'(size_out));
            check_val("eip_out", data_w'(exp_eip_q.pop_front()), data_w'(eip_out));
            for (int i = 0; i < num_ops; i++) begin
                check_val($sformatf("op_val[%0d]", i), ops[i], op_val[i]);
            end
            for (int j = 0; j < num_dests; j++) begin
                check_val($sformatf("dest_addr[%0d]", j), data_w'(daddr[j]), data_w'(dest_addr[j]));
                check_val($sformatf("dest_kind[%0d]", j), data_w'(dkind[j]), data_w'(dest_kind[j]));
            end
        end
    endtask

    task automatic check_write();
        logic [addr_w-1:0] a;
        logic [data_w-1:0] d;
        logic [size_bits-1:0] sz;
        if (wr_addr_q.size() == 0) begin
            $display("mem_wr came with no writeback outstanding");
            proto_errors++;
        end else begin
            a = wr_addr_q.pop_front();
            d = wr_data_q.pop_front();
            sz = wr_size_q.pop_front();
            check_val("mem_wr_addr", data_w'(a), data_w'(mem_wr_addr));
            check_val("mem_wr_data", d, mem_wr_data);
            check_val("mem_wr_size", data_w'(sz), data_w'(mem_wr_size));
            for (int k = 0; k < (1 << sz); k++) begin
                ext_mem[widx(a + k)] = d[k*8 +: 8];
            end
        end
    endtask

    task automatic take_fill();
        if (fill_open || fills_seen != 0 || !(valid_in && mem_rd && cur_miss)) begin
            $display("fill request at %h without a single outstanding miss", fill_addr);
            proto_errors++;
        end
        check_val("fill_addr", data_w'(mem_addr & ~addr_w'(line_bytes - 1)),
                  data_w'(fill_addr));
        fills_seen++;
        fill_open = 1'b1;
        fill_line = fill_addr;
        fill_wait = int'($urandom % 5);
    endtask

    task automatic answer_fill();
        logic [line_w-1:0] line;
        fill_valid <= 1'b0;
        if (fill_open && fill_wait == 0) begin
            for (int b = 0; b < line_bytes; b++) begin
                line[b*8 +: 8] = ext_mem[widx(fill_line + b)];
            end
            fill_valid <= 1'b1;
            fill_data <= line;
            model_valid[fill_line[off_w +: idx_w]] = 1'b1;
            model_tag[fill_line[off_w +: idx_w]] = fill_line[addr_w-1 -: tag_w];
            fill_open = 1'b0;
        end else if (fill_open) begin
            fill_wait--;
        end
    endtask

    task automatic drive_instr();
        logic [size_bits-1:0] osz;
        logic [num_sizes-1:0] ovr;
        logic [addr_w-1:0] a;
        logic rd;
        logic [num_ops-1:0][src_bits-1:0] ops;
        osz = size_bits'($urandom);
        case ($urandom % 4)
            0, 1: ovr = '0;
            2: ovr = num_sizes'(1 << ($urandom % 4));
            default: ovr = num_sizes'($urandom);
        endcase
        a = win_base + (($urandom % win_bytes) & ~((32'd1 << access_size(ovr, osz)) - 1));
        rd = ($urandom % 5) < 3;
        for (int i = 0; i < num_ops; i++) begin
            ops[i] = src_bits'($urandom);
            if (ops[i] == src_mem && !rd) ops[i] = src_imm;   // no loaded item without a read.
        end
        cur_miss = rd && !(model_valid[a[off_w +: idx_w]] &&
                           model_tag[a[off_w +: idx_w]] == a[addr_w-1 -: tag_w]);
        fills_seen = 0;
        line_in = 1'b0;
        driven++;
        for (int i = 0; i < num_srcs; i++) begin
            reg_data[i] <= {$urandom, $urandom};
            seg_data[i] <= seg_w'($urandom);
        end
        valid_in <= 1'b1;
        fwd_stall <= ($urandom % 5 == 0);
        opsize_in <= osz;
        memsize_ovr <= ovr;
        mem_rd <= rd;
        mem_addr <= a;
        imm <= {$urandom, $urandom};
        eip_in <= $urandom;
        op_sel <= ops;
        dest_sel <= {src_bits'($urandom), src_bits'($urandom)};
    endtask

    task automatic drive_wb();
        logic [size_bits-1:0] sz;
        logic [addr_w-1:0] a;
        logic [data_w-1:0] d;
        sz = size_bits'($urandom);
        a = win_base + (($urandom % win_bytes) & ~((32'd1 << sz) - 1));
        d = {$urandom, $urandom};
        for (int k = 0; k < (1 << sz); k++) begin
            ref_mem[widx(a + k)] = d[k*8 +: 8];
        end
        wr_addr_q.push_back(a);
        wr_data_q.push_back(d);
        wr_size_q.push_back(sz);
        valid_in <= 1'b0;
        fwd_stall <= 1'b0;
        wb_valid <= 1'b1;
        wb_addr <= a;
        wb_data <= d;
        wb_size <= sz;
    endtask

    initial begin
        rnd = $urandom(32'h924cc76f);
        rst = 1'b1;
        valid_in = 1'b0;
        fwd_stall = 1'b0;
        opsize_in = '0;
        memsize_ovr = '0;
        mem_rd = 1'b0;
        mem_addr = '0;
        reg_data = '0;
        seg_data = '0;
        imm = '0;
        eip_in = '0;
        op_sel = '0;
        dest_sel = '0;
        wb_valid = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        wb_size = '0;
        fill_valid = 1'b0;
        fill_data = '0;
        value_errors = 0;
        proto_errors = 0;
        driven = 0;
        accepted = 0;
        fills_seen = 0;
        fill_wait = 0;
        fill_open = 1'b0;
        cur_miss = 1'b0;
        line_in = 1'b0;
        prev_stall = 1'b0;
        prev_wb = 1'b0;
        model_valid = '0;
        for (int i = 0; i < win_bytes; i++) begin
            ref_mem[i] = init_byte(win_base + i);
            ext_mem[i] = init_byte(win_base + i);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        while (accepted < n_instr || exp_size_q.size() != 0 || wr_addr_q.size() != 0 ||
               fill_open) begin
            @(posedge clk);
            if (valid_out) check_output();
            if (valid_out && prev_stall) begin
                $display("valid_out rose right after a stall cycle");
                proto_errors++;
            end
            prev_stall = stall;
            // a load stalls until the cycle after its fill, hits never stall.
            check_val("stall", data_w'(fwd_stall || (valid_in && cur_miss && !line_in)),
                      data_w'(stall));
            if (fill_valid) line_in = 1'b1;
            check_val("mem_wr", data_w'(prev_wb), data_w'(mem_wr));
            prev_wb = wb_valid;
            if (mem_wr) check_write();
            if (fill_req) take_fill();
            answer_fill();
            if (valid_in && !stall) begin
                if (fills_seen != (cur_miss ? 1 : 0)) begin
                    $display("load at %h saw %0d fill requests", mem_addr, fills_seen);
                    proto_errors++;
                end
                push_expected();
                accepted++;
            end
            wb_valid <= 1'b0;
            if (valid_in && stall) begin
                fwd_stall <= ($urandom % 5 == 0);   // instruction stays put.
            end else if (driven < n_instr) begin
                rnd = $urandom % 8;
                if (rnd == 0) begin
                    valid_in <= 1'b0;
                    fwd_stall <= ($urandom % 2 == 0);
                end else if (rnd == 1) begin
                    drive_wb();
                end else begin
                    drive_instr();
                end
            end else begin
                valid_in <= 1'b0;
                fwd_stall <= 1'b0;
            end
        end

        $display("instructions %0d, value errors %0d, protocol errors %0d",
                 accepted, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
